//--- hw/cache_macros.svh
// cache geometry macros
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// 8 sets of 4 ways, 13-bit line address
`define CACHE_NUM_WAYS 4
`define CACHE_NUM_SETS 8
`define CACHE_IDX_BITS 3
`define CACHE_TAG_BITS 10
`define CACHE_DATA_BITS 64

`define CACHE_RD_PORTS 2

// register block
`define CSR_DATA_BITS 32

`endif

//--- hw/cache_pkg.sv
// cache types
`default_nettype none

package cache_pkg;

  `include "cache_macros.svh"

  typedef logic [`CACHE_IDX_BITS-1:0] cache_idx_t;
  typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;
  typedef logic [`CACHE_DATA_BITS-1:0] cache_data_t;
  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] cache_way_t;

  // one stored line, 76 bits
  typedef struct packed {
    cache_data_t data;
    cache_tag_t  tag;
    logic        valid;
    logic        dirty;
  } cache_line_t;

  // tree bits of one set: root, lower pair, upper pair
  typedef logic [`CACHE_NUM_WAYS-2:0] plru_bits_t;

  typedef logic [2:0] csr_addr_t;
  typedef logic [`CSR_DATA_BITS-1:0] csr_data_t;

endpackage

`default_nettype wire

//--- hw/tag_cam.sv
// set tag compare
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tag_cam import cache_pkg::*; (
  input  cache_line_t [`CACHE_NUM_WAYS-1:0] lines,
  input  cache_tag_t                        tag,
  input  logic                              enable,
  output logic                              hit,
  output cache_way_t                        way
);

  logic [`CACHE_NUM_WAYS-1:0] match;

  // only valid ways take part
  always_comb begin
    match = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      match[w] = lines[w].valid && (lines[w].tag == tag);
    end
  end

  assign hit = enable && (|match);

  always_comb begin
    way = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (match[w]) begin
        way = cache_way_t'(w);
      end
    end
  end

  // fills happen only on a miss, so a tag lives in at most one way of a set
  always_comb begin
    if (enable) begin
      assert final ($onehot0(match))
        else $error("tag_cam: tag found in more than one valid way");
    end
  end

endmodule

`default_nettype wire

//--- hw/plru_tree.sv
// tree pseudo-LRU state
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module plru_tree import cache_pkg::*; (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   flush,
  input  logic                                   wr_touch,
  input  cache_idx_t                             wr_touch_idx,
  input  cache_way_t                             wr_touch_way,
  input  logic                                   wr_fill,
  input  cache_idx_t                             wr_fill_idx,
  input  logic       [`CACHE_RD_PORTS-1:0]       rd_touch,
  input  cache_idx_t [`CACHE_RD_PORTS-1:0]       rd_touch_idx,
  input  cache_way_t [`CACHE_RD_PORTS-1:0]       rd_touch_way,
  output cache_way_t                             fill_way
);

  plru_bits_t [`CACHE_NUM_SETS-1:0] plru_q;
  plru_bits_t [`CACHE_NUM_SETS-1:0] plru_next;

  // point every node on the way's path away from it
  function automatic plru_bits_t plru_touch(input plru_bits_t bits, input cache_way_t way);
    plru_bits_t upd;
    upd = bits;
    upd[0] = ~way[1];
    if (way[1]) begin
      upd[2] = ~way[0];
    end else begin
      upd[1] = ~way[0];
    end
    return upd;
  endfunction

  // a node bit of 1 sends the victim to the upper half
  function automatic cache_way_t plru_victim(input plru_bits_t bits);
    cache_way_t way;
    if (bits[0]) begin
      way = {1'b1, bits[2]};
    end else begin
      way = {1'b0, bits[1]};
    end
    return way;
  endfunction

  assign fill_way = plru_victim(plru_q[wr_fill_idx]);

  // write first, then read port 0, then read port 1
  always_comb begin
    plru_next = plru_q;
    if (wr_touch) begin
      plru_next[wr_touch_idx] = plru_touch(plru_next[wr_touch_idx], wr_touch_way);
    end
    if (wr_fill) begin
      plru_next[wr_fill_idx] = plru_touch(plru_next[wr_fill_idx], fill_way);
    end
    for (int p = 0; p < `CACHE_RD_PORTS; p++) begin
      if (rd_touch[p]) begin
        plru_next[rd_touch_idx[p]] = plru_touch(plru_next[rd_touch_idx[p]], rd_touch_way[p]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      plru_q <= '0;
    end else begin
      plru_q <= plru_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/cache_array.sv
// cache line storage and lookup
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_array import cache_pkg::*; (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    cache_enable,
  input  logic                                    flush,
  // read ports
  input  logic        [`CACHE_RD_PORTS-1:0]       rd_en,
  input  cache_idx_t  [`CACHE_RD_PORTS-1:0]       rd_idx,
  input  cache_tag_t  [`CACHE_RD_PORTS-1:0]       rd_tag,
  output cache_data_t [`CACHE_RD_PORTS-1:0]       rd_data,
  output logic        [`CACHE_RD_PORTS-1:0]       rd_valid,
  output logic        [`CACHE_RD_PORTS-1:0]       rd_miss_valid,
  // write port
  input  logic                                    wr_en,
  input  cache_idx_t                              wr_idx,
  input  cache_tag_t                              wr_tag,
  input  cache_data_t                             wr_data,
  output logic                                    wr_miss_valid,
  output cache_line_t                             victim_line,
  output logic                                    victim_valid,
  // pseudo-LRU
  input  cache_way_t                              fill_way,
  output logic                                    wr_touch,
  output cache_idx_t                              wr_touch_idx,
  output cache_way_t                              wr_touch_way,
  output logic                                    wr_fill,
  output cache_idx_t                              wr_fill_idx,
  output logic        [`CACHE_RD_PORTS-1:0]       rd_touch,
  output cache_idx_t  [`CACHE_RD_PORTS-1:0]       rd_touch_idx,
  output cache_way_t  [`CACHE_RD_PORTS-1:0]       rd_touch_way,
  // event strobes
  output logic        [`CACHE_RD_PORTS-1:0]       rd_hit_event,
  output logic        [`CACHE_RD_PORTS-1:0]       rd_miss_event,
  output logic                                    wr_miss_event,
  output logic                                    victim_event
);

  cache_data_t [`CACHE_NUM_WAYS-1:0] data_q [`CACHE_NUM_SETS];
  cache_tag_t  [`CACHE_NUM_WAYS-1:0] tag_q  [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] valid_q;
  logic [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] dirty_q;

  cache_line_t [`CACHE_NUM_WAYS-1:0] set_lines [`CACHE_NUM_SETS];

  logic       [`CACHE_RD_PORTS-1:0] rd_hit;
  cache_way_t [`CACHE_RD_PORTS-1:0] rd_way;
  logic       [`CACHE_RD_PORTS-1:0] rd_fwd;

  logic        wr_act;
  logic        wr_hit;
  cache_way_t  wr_hit_way;
  cache_way_t  wr_way;
  cache_line_t old_line;

  for (genvar s = 0; s < `CACHE_NUM_SETS; s++) begin : g_set
    for (genvar w = 0; w < `CACHE_NUM_WAYS; w++) begin : g_way
      assign set_lines[s][w] = {data_q[s][w], tag_q[s][w], valid_q[s][w], dirty_q[s][w]};
    end
  end

  // disabled cache behaves as all-miss, no writes
  assign wr_act = wr_en && cache_enable;

  for (genvar p = 0; p < `CACHE_RD_PORTS; p++) begin : g_rd
    tag_cam rd_cam_inst (
      .lines  (set_lines[rd_idx[p]]),
      .tag    (rd_tag[p]),
      .enable (rd_en[p] && cache_enable),
      .hit    (rd_hit[p]),
      .way    (rd_way[p])
    );

    // write data wins over the stored line
    assign rd_fwd[p] = rd_en[p] && wr_act && (wr_idx == rd_idx[p]) && (wr_tag == rd_tag[p]);

    assign rd_valid[p] = rd_fwd[p] || rd_hit[p];
    assign rd_data[p] = rd_fwd[p] ? wr_data :
                        rd_hit[p] ? set_lines[rd_idx[p]][rd_way[p]].data : '0;
    assign rd_miss_valid[p] = rd_en[p] && !rd_valid[p];

    assign rd_touch[p] = rd_hit[p];
    assign rd_touch_idx[p] = rd_idx[p];
    assign rd_touch_way[p] = rd_way[p];

    assign rd_hit_event[p] = rd_valid[p];
    assign rd_miss_event[p] = rd_miss_valid[p];
  end

  tag_cam wr_cam_inst (
    .lines  (set_lines[wr_idx]),
    .tag    (wr_tag),
    .enable (wr_act),
    .hit    (wr_hit),
    .way    (wr_hit_way)
  );

  assign wr_miss_valid = wr_act && !wr_hit;
  assign wr_way = wr_hit ? wr_hit_way : fill_way;

  assign wr_touch = wr_hit;
  assign wr_touch_idx = wr_idx;
  assign wr_touch_way = wr_hit_way;
  assign wr_fill = wr_miss_valid;
  assign wr_fill_idx = wr_idx;

  // line about to be replaced
  assign old_line = set_lines[wr_idx][fill_way];
  assign victim_line = wr_miss_valid ? old_line : '0;
  assign victim_valid = wr_miss_valid && old_line.valid;

  assign wr_miss_event = wr_miss_valid;
  assign victim_event = victim_valid;

  always_ff @(posedge clock) begin
    if (wr_act) begin
      data_q[wr_idx][wr_way] <= wr_data;
      tag_q[wr_idx][wr_way] <= wr_tag;
    end
  end

  // hit marks dirty, fill comes in clean
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_act) begin
      valid_q[wr_idx][wr_way] <= 1'b1;
      dirty_q[wr_idx][wr_way] <= wr_hit;
    end
  end

  // flush pulse comes from the register block, writes from the core side
  assert property (@(posedge clock) disable iff (reset) !(wr_en && flush))
    else $error("cache_array: write in the flush cycle");

endmodule

`default_nettype wire

//--- hw/cache_csr.sv
// cache control and counters
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_csr import cache_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        csr_wr_en,
  input  csr_addr_t                   csr_addr,
  input  csr_data_t                   csr_wdata,
  output csr_data_t                   csr_rdata,
  output logic                        cache_enable,
  output logic                        flush,
  input  logic [`CACHE_RD_PORTS-1:0]  rd_hit_event,
  input  logic [`CACHE_RD_PORTS-1:0]  rd_miss_event,
  input  logic                        wr_miss_event,
  input  logic                        victim_event
);

  localparam csr_addr_t ADDR_CTRL = 3'd0;
  localparam csr_addr_t ADDR_RD_HIT = 3'd1;
  localparam csr_addr_t ADDR_RD_MISS = 3'd2;
  localparam csr_addr_t ADDR_WR_MISS = 3'd3;
  localparam csr_addr_t ADDR_VICTIM = 3'd4;

  csr_data_t rd_hit_count;
  csr_data_t rd_miss_count;
  csr_data_t wr_miss_count;
  csr_data_t victim_count;

  // flush is a one-cycle pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      cache_enable <= 1'b1;
      flush <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (csr_wr_en && (csr_addr == ADDR_CTRL)) begin
        cache_enable <= csr_wdata[0];
        flush <= csr_wdata[1];
      end
    end
  end

  // both read ports can count in one cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_hit_count <= '0;
      rd_miss_count <= '0;
      wr_miss_count <= '0;
      victim_count <= '0;
    end else begin
      rd_hit_count <= rd_hit_count + csr_data_t'($countones(rd_hit_event));
      rd_miss_count <= rd_miss_count + csr_data_t'($countones(rd_miss_event));
      wr_miss_count <= wr_miss_count + csr_data_t'(wr_miss_event);
      victim_count <= victim_count + csr_data_t'(victim_event);
    end
  end

  always_comb begin
    case (csr_addr)
      ADDR_CTRL:    csr_rdata = csr_data_t'(cache_enable);
      ADDR_RD_HIT:  csr_rdata = rd_hit_count;
      ADDR_RD_MISS: csr_rdata = rd_miss_count;
      ADDR_WR_MISS: csr_rdata = wr_miss_count;
      ADDR_VICTIM:  csr_rdata = victim_count;
      default:      csr_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/cache_top.sv
// line cache top level
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_top import cache_pkg::*; (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic        [`CACHE_RD_PORTS-1:0]       rd_en,
  input  cache_idx_t  [`CACHE_RD_PORTS-1:0]       rd_idx,
  input  cache_tag_t  [`CACHE_RD_PORTS-1:0]       rd_tag,
  output cache_data_t [`CACHE_RD_PORTS-1:0]       rd_data,
  output logic        [`CACHE_RD_PORTS-1:0]       rd_valid,
  output logic        [`CACHE_RD_PORTS-1:0]       rd_miss_valid,
  input  logic                                    wr_en,
  input  cache_idx_t                              wr_idx,
  input  cache_tag_t                              wr_tag,
  input  cache_data_t                             wr_data,
  output logic                                    wr_miss_valid,
  output cache_line_t                             victim_line,
  output logic                                    victim_valid,
  input  logic                                    csr_wr_en,
  input  csr_addr_t                               csr_addr,
  input  csr_data_t                               csr_wdata,
  output csr_data_t                               csr_rdata
);

  logic cache_enable;
  logic flush;
  cache_way_t fill_way;
  logic wr_touch;
  cache_idx_t wr_touch_idx;
  cache_way_t wr_touch_way;
  logic wr_fill;
  cache_idx_t wr_fill_idx;
  logic       [`CACHE_RD_PORTS-1:0] rd_touch;
  cache_idx_t [`CACHE_RD_PORTS-1:0] rd_touch_idx;
  cache_way_t [`CACHE_RD_PORTS-1:0] rd_touch_way;
  logic [`CACHE_RD_PORTS-1:0] rd_hit_event;
  logic [`CACHE_RD_PORTS-1:0] rd_miss_event;
  logic wr_miss_event;
  logic victim_event;

  cache_array cache_array_inst (
    .clock         (clock),
    .reset         (reset),
    .cache_enable  (cache_enable),
    .flush         (flush),
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .rd_tag        (rd_tag),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .rd_miss_valid (rd_miss_valid),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_tag        (wr_tag),
    .wr_data       (wr_data),
    .wr_miss_valid (wr_miss_valid),
    .victim_line   (victim_line),
    .victim_valid  (victim_valid),
    .fill_way      (fill_way),
    .wr_touch      (wr_touch),
    .wr_touch_idx  (wr_touch_idx),
    .wr_touch_way  (wr_touch_way),
    .wr_fill       (wr_fill),
    .wr_fill_idx   (wr_fill_idx),
    .rd_touch      (rd_touch),
    .rd_touch_idx  (rd_touch_idx),
    .rd_touch_way  (rd_touch_way),
    .rd_hit_event  (rd_hit_event),
    .rd_miss_event (rd_miss_event),
    .wr_miss_event (wr_miss_event),
    .victim_event  (victim_event)
  );

  plru_tree plru_tree_inst (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .wr_touch     (wr_touch),
    .wr_touch_idx (wr_touch_idx),
    .wr_touch_way (wr_touch_way),
    .wr_fill      (wr_fill),
    .wr_fill_idx  (wr_fill_idx),
    .rd_touch     (rd_touch),
    .rd_touch_idx (rd_touch_idx),
    .rd_touch_way (rd_touch_way),
    .fill_way     (fill_way)
  );

  cache_csr cache_csr_inst (
    .clock         (clock),
    .reset         (reset),
    .csr_wr_en     (csr_wr_en),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata),
    .cache_enable  (cache_enable),
    .flush         (flush),
    .rd_hit_event  (rd_hit_event),
    .rd_miss_event (rd_miss_event),
    .wr_miss_event (wr_miss_event),
    .victim_event  (victim_event)
  );

endmodule

`default_nettype wire

//--- tb/cache_tb.sv
// line cache testbench
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tb import cache_pkg::*; ();

  localparam int CLOCK_PERIOD = 20;
  localparam int READY_TIMEOUT = 16;
  localparam int NUM_SLOTS = 16;

  // line addresses are {tag, set}
  localparam logic [12:0] LINE_A = {10'h011, 3'd2};
  localparam logic [12:0] LINE_B = {10'h022, 3'd2};
  localparam logic [12:0] LINE_C = {10'h033, 3'd2};
  localparam logic [12:0] LINE_D = {10'h044, 3'd2};
  localparam logic [12:0] LINE_E = {10'h055, 3'd2};
  localparam logic [12:0] LINE_F = {10'h066, 3'd2};
  localparam logic [12:0] LINE_K = {10'h101, 3'd2};
  localparam logic [12:0] LINE_L = {10'h202, 3'd2};
  localparam logic [12:0] LINE_M = {10'h303, 3'd2};
  localparam logic [12:0] LINE_N = {10'h0ab, 3'd2};
  localparam logic [12:0] LINE_P = {10'h1cd, 3'd2};
  localparam logic [12:0] LINE_J = {10'h0f0, 3'd3};
  localparam logic [12:0] LINE_X = {10'h1c3, 3'd5};
  localparam logic [12:0] LINE_H = {10'h3a1, 3'd6};

  typedef struct {
    string       name;
    logic        csr_we;
    csr_addr_t   csr_addr;
    csr_data_t   csr_wdata;
    csr_data_t   exp_csr;
    logic [1:0]  rd_en;
    logic [12:0] rd_line0;
    logic [12:0] rd_line1;
    logic        wr_en;
    logic [12:0] wr_line;
    int          wr_slot;
    logic [1:0]  exp_valid;
    int          exp_slot0;
    int          exp_slot1;
    logic        exp_wr_miss;
    int          victim_slot;
    logic [12:0] victim_addr;
    logic        exp_victim;
    logic        victim_dirty;
  } row_t;

  logic clock;
  logic reset;
  logic        [`CACHE_RD_PORTS-1:0] rd_en;
  cache_idx_t  [`CACHE_RD_PORTS-1:0] rd_idx;
  cache_tag_t  [`CACHE_RD_PORTS-1:0] rd_tag;
  cache_data_t [`CACHE_RD_PORTS-1:0] rd_data;
  logic        [`CACHE_RD_PORTS-1:0] rd_valid;
  logic        [`CACHE_RD_PORTS-1:0] rd_miss_valid;
  logic        wr_en;
  cache_idx_t  wr_idx;
  cache_tag_t  wr_tag;
  cache_data_t wr_data;
  logic        wr_miss_valid;
  cache_line_t victim_line;
  logic        victim_valid;
  logic        csr_wr_en;
  csr_addr_t   csr_addr;
  csr_data_t   csr_wdata;
  csr_data_t   csr_rdata;

  row_t        rows[$];
  cache_data_t slot_data [NUM_SLOTS];
  logic [31:0] lfsr_state;

  cache_top cache_top_inst (
    .clock         (clock),
    .reset         (reset),
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .rd_tag        (rd_tag),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .rd_miss_valid (rd_miss_valid),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_tag        (wr_tag),
    .wr_data       (wr_data),
    .wr_miss_valid (wr_miss_valid),
    .victim_line   (victim_line),
    .victim_valid  (victim_valid),
    .csr_wr_en     (csr_wr_en),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic random_word(output cache_data_t word);
    word = '0;
    for (int i = 0; i < `CACHE_DATA_BITS; i++) begin
      word = {word[`CACHE_DATA_BITS-2:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_data(input string name, input cache_data_t expected,
                              input cache_data_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_line(input string name, input cache_line_t expected,
                              input cache_line_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic compare_csr(input string name, input csr_data_t expected,
                             input csr_data_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic void add_row(input string name, input logic csr_we, input csr_addr_t ca,
                                  input csr_data_t cw, input csr_data_t ecsr,
                                  input logic [1:0] ren, input logic [12:0] rl0,
                                  input logic [12:0] rl1, input logic wen,
                                  input logic [12:0] wl, input int ws,
                                  input logic [1:0] ev, input int es0, input int es1,
                                  input logic ewm, input int vs, input logic [12:0] vl,
                                  input logic vv, input logic vd);
    row_t row;
    row = '{name, csr_we, ca, cw, ecsr, ren, rl0, rl1, wen, wl, ws, ev, es0, es1, ewm,
            vs, vl, vv, vd};
    rows.push_back(row);
  endfunction

  // name, csr we/addr/wdata/expected, rd_en, rd lines, wr_en, wr line, data slot,
  // expected rd_valid and slots, wr miss, victim slot (-1 none), victim line, valid, dirty
  function automatic void build_table();
    add_row("reset_miss", 0, 1, 0, 0, 3, LINE_A, LINE_X, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    // fill order in an empty set is 0, 2, 1, 3
    add_row("fill_way0", 0, 3, 0, 0, 0, 0, 0, 1, LINE_A, 0, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("fill_way2", 0, 2, 0, 2, 0, 0, 0, 1, LINE_B, 1, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("fill_way1", 0, 5, 0, 0, 0, 0, 0, 1, LINE_C, 2, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("fill_way3", 0, 4, 0, 0, 0, 0, 0, 1, LINE_D, 3, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("read_a_b", 0, 5, 0, 0, 3, LINE_A, LINE_B, 0, 0, -1, 3, 0, 1, 0, -1, 0, 0, 0);
    // touching ways 1 then 3 points the tree back at way 0
    add_row("read_c_d", 0, 5, 0, 0, 3, LINE_C, LINE_D, 0, 0, -1, 3, 2, 3, 0, -1, 0, 0, 0);
    add_row("evict_a", 0, 5, 0, 0, 0, 0, 0, 1, LINE_E, 4, 0, -1, -1, 1, 0, LINE_A, 1, 0);
    add_row("a_gone", 0, 5, 0, 0, 3, LINE_A, LINE_E, 0, 0, -1, 2, -1, 4, 0, -1, 0, 0, 0);
    add_row("write_hit_b", 0, 5, 0, 0, 0, 0, 0, 1, LINE_B, 5, 0, -1, -1, 0, -1, 0, 0, 0);
    // way 3 then way 0 leaves way 2 as victim
    add_row("read_d_e", 0, 5, 0, 0, 3, LINE_D, LINE_E, 0, 0, -1, 3, 3, 4, 0, -1, 0, 0, 0);
    add_row("evict_dirty_b", 0, 5, 0, 0, 0, 0, 0, 1, LINE_F, 6, 0, -1, -1, 1, 5, LINE_B, 1, 1);
    add_row("forward_new", 0, 5, 0, 0, 3, LINE_H, LINE_F, 1, LINE_H, 7, 3, 7, 6, 1, -1, 0, 0, 0);
    add_row("disable", 1, 0, 0, 1, 0, 0, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("disabled_rw", 0, 0, 0, 0, 3, LINE_H, LINE_F, 1, LINE_J, 8, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("enable", 1, 0, 1, 0, 1, LINE_J, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("j_not_written", 0, 0, 0, 1, 3, LINE_J, LINE_H, 0, 0, -1, 2, -1, 7, 0, -1, 0, 0, 0);
    add_row("flush_write", 1, 0, 3, 1, 1, LINE_F, 0, 0, 0, -1, 1, 6, -1, 0, -1, 0, 0, 0);
    add_row("flush_pulse", 0, 0, 0, 1, 0, 0, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("flushed_miss", 0, 5, 0, 0, 3, LINE_F, LINE_H, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    // fills start from way 0 again
    // way 0 still holds the old E line, now invalid
    add_row("refill_k", 0, 5, 0, 0, 0, 0, 0, 1, LINE_K, 9, 0, -1, -1, 1, 4, LINE_E, 0, 0);
    add_row("refill_l", 0, 5, 0, 0, 0, 0, 0, 1, LINE_L, 10, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("refill_m", 0, 5, 0, 0, 0, 0, 0, 1, LINE_M, 11, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("refill_n", 0, 5, 0, 0, 0, 0, 0, 1, LINE_N, 12, 0, -1, -1, 1, -1, 0, 0, 0);
    add_row("evict_k", 0, 5, 0, 0, 0, 0, 0, 1, LINE_P, 13, 0, -1, -1, 1, 9, LINE_K, 1, 0);
    add_row("count_rd_hit", 0, 1, 0, 11, 0, 0, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("count_rd_miss", 0, 2, 0, 9, 0, 0, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("count_wr_miss", 0, 3, 0, 12, 0, 0, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
    add_row("count_victim", 0, 4, 0, 3, 0, 0, 0, 0, 0, -1, 0, -1, -1, 0, -1, 0, 0, 0);
  endfunction

  task automatic check_read_port(input row_t row, input int p);
    logic exp_valid;
    int   slot;
    exp_valid = row.exp_valid[p];
    slot = (p == 0) ? row.exp_slot0 : row.exp_slot1;
    compare_flag($sformatf("%s rd_valid[%0d]", row.name, p), exp_valid, rd_valid[p]);
    compare_flag($sformatf("%s rd_miss_valid[%0d]", row.name, p),
                 row.rd_en[p] && !exp_valid, rd_miss_valid[p]);
    if (exp_valid) begin
      compare_data($sformatf("%s rd_data[%0d]", row.name, p), slot_data[slot], rd_data[p]);
    end
  endtask

  task automatic apply_row(input row_t row);
    cache_data_t word;
    cache_line_t exp_line;
    @(posedge clock);
    #1;
    csr_wr_en = row.csr_we;
    csr_addr = row.csr_addr;
    csr_wdata = row.csr_wdata;
    rd_en = row.rd_en;
    rd_idx[0] = row.rd_line0[2:0];
    rd_tag[0] = row.rd_line0[12:3];
    rd_idx[1] = row.rd_line1[2:0];
    rd_tag[1] = row.rd_line1[12:3];
    wr_en = row.wr_en;
    wr_idx = row.wr_line[2:0];
    wr_tag = row.wr_line[12:3];
    wr_data = '0;
    if (row.wr_slot >= 0) begin
      random_word(word);
      slot_data[row.wr_slot] = word;
      wr_data = word;
    end
    // sample just before the next edge
    #17;
    compare_csr({row.name, " csr_rdata"}, row.exp_csr, csr_rdata);
    check_read_port(row, 0);
    check_read_port(row, 1);
    compare_flag({row.name, " wr_miss_valid"}, row.exp_wr_miss, wr_miss_valid);
    compare_flag({row.name, " victim_valid"}, row.exp_victim, victim_valid);
    if (row.victim_slot >= 0) begin
      exp_line.data = slot_data[row.victim_slot];
      exp_line.tag = row.victim_addr[12:3];
      exp_line.valid = row.exp_victim;
      exp_line.dirty = row.victim_dirty;
      compare_line({row.name, " victim_line"}, exp_line, victim_line);
    end
  endtask

  task automatic wait_for_enable();
    int cycles;
    cycles = 0;
    csr_addr = 3'd0;
    #1;
    while (csr_rdata[0] !== 1'b1) begin
      if (cycles == READY_TIMEOUT) begin
        stop_with_failure("cache enable bit did not come up after reset");
      end
      @(posedge clock);
      #1;
      cycles++;
    end
  endtask

  initial begin
    lfsr_state = 32'h65ae;
    reset = 1'b1;
    rd_en = '0;
    rd_idx = '0;
    rd_tag = '0;
    wr_en = 1'b0;
    wr_idx = '0;
    wr_tag = '0;
    wr_data = '0;
    csr_wr_en = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    build_table();
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    wait_for_enable();
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/cache_pkg.sv
hw/tag_cam.sv
hw/plru_tree.sv
hw/cache_array.sv
hw/cache_csr.sv
hw/cache_top.sv
tb/cache_tb.sv

//--- Makefile
# Verilator build and run for the line cache testbench
# all variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
